//--- common/core_region_macros.svh
`ifndef CORE_REGION_MACROS_SVH
`define CORE_REGION_MACROS_SVH

// load/store bus widths
`define CR_ADDR_W 32
`define CR_DATA_W 32
`define CR_BE_W 4

// local data RAM geometry, in 32-bit words
`define CR_RAM_AW 10
`define CR_RAM_WORDS 1024

// addr[31:20] of the local region
`define CR_REGION_TAG 12'h001

`define CR_IRQ_N 32
`define CR_IRQ_ID_W 5

`endif

//--- common/core_region_pkg.sv
`include "core_region_macros.svh"

package core_region_pkg;

  // core load/store request, byte addressed
  typedef struct packed {
    logic [`CR_ADDR_W-1:0] addr;
    logic                  we;
    logic [`CR_BE_W-1:0]   be;
    logic [`CR_DATA_W-1:0] wdata;
  } lsu_req_t;

  // single RAM access, word addressed
  typedef struct packed {
    logic [`CR_RAM_AW-1:0] addr;
    logic                  we;
    logic [`CR_BE_W-1:0]   be;
    logic [`CR_DATA_W-1:0] wdata;
  } ram_req_t;

  // target that owes the next lsu response
  typedef enum logic {
    RESP_RAM = 1'b0,
    RESP_EXT = 1'b1
  } resp_src_e;

endpackage

//--- data_mem/data_ram.sv
`timescale 1ns/1ps

`include "core_region_macros.svh"

module data_ram
  import core_region_pkg::*;
(
  input  logic                  clk,
  input  logic                  ram_en_i,
  input  ram_req_t              ram_data_i,
  output logic [`CR_DATA_W-1:0] ram_rdata_o
);

  logic [`CR_DATA_W-1:0] mem [`CR_RAM_WORDS];

  // byte-wise write, whole-word read
  always_ff @(posedge clk) begin
    if (ram_en_i) begin
      if (ram_data_i.we) begin
        for (int b = 0; b < `CR_BE_W; b++) begin
          if (ram_data_i.be[b]) begin
            mem[ram_data_i.addr][b*8 +: 8] <= ram_data_i.wdata[b*8 +: 8];
          end
        end
      end else begin
        ram_rdata_o <= mem[ram_data_i.addr];
      end
    end
  end

  // output holds the last read word until the next read

endmodule

//--- data_mem/data_ram_arbiter.sv
`timescale 1ns/1ps

`include "core_region_macros.svh"

module data_ram_arbiter
  import core_region_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // system port, always served
  input  logic                  sys_req_i,
  input  ram_req_t              sys_data_i,
  output logic [`CR_DATA_W-1:0] sys_rdata_o,

  // core port, byte addressed
  input  logic                  core_req_i,
  input  lsu_req_t              core_data_i,
  output logic                  core_gnt_o,
  output logic                  core_rvalid_o,
  output logic [`CR_DATA_W-1:0] core_rdata_o,

  // to the RAM
  output logic                  ram_en_o,
  output ram_req_t              ram_data_o,
  input  logic [`CR_DATA_W-1:0] ram_rdata_i
);

  ram_req_t core_ram_req;
  logic     core_rvalid_q;

  // byte address to word address
  always_comb begin
    core_ram_req.addr  = core_data_i.addr[`CR_RAM_AW+1:2];
    core_ram_req.we    = core_data_i.we;
    core_ram_req.be    = core_data_i.be;
    core_ram_req.wdata = core_data_i.wdata;
  end

  // fixed priority, system port first
  assign core_gnt_o = core_req_i & ~sys_req_i;
  assign ram_en_o   = sys_req_i | core_req_i;
  assign ram_data_o = sys_req_i ? sys_data_i : core_ram_req;

  // RAM answers one cycle after the grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_rvalid_q <= 1'b0;
    end else begin
      core_rvalid_q <= core_gnt_o;
    end
  end

  assign core_rvalid_o = core_rvalid_q;

  // read word goes to both ports, each knows when it is its own
  assign core_rdata_o = ram_rdata_i;
  assign sys_rdata_o  = ram_rdata_i;

endmodule

//--- hw/irq_encoder.sv
`timescale 1ns/1ps

`include "core_region_macros.svh"

module irq_encoder (
  input  logic [`CR_IRQ_N-1:0]    irq_i,
  output logic                    irq_o,
  output logic [`CR_IRQ_ID_W-1:0] irq_id_o
);

  assign irq_o = |irq_i;

  // last hit wins, so the highest set line ends up in irq_id_o
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < `CR_IRQ_N; i++) begin
      if (irq_i[i]) begin
        irq_id_o = i[`CR_IRQ_ID_W-1:0];
      end
    end
  end

endmodule

//--- hw/lsu_router.sv
`timescale 1ns/1ps

`include "core_region_macros.svh"

module lsu_router
  import core_region_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // from the core
  input  logic                  lsu_req_i,
  input  lsu_req_t              lsu_data_i,
  output logic                  lsu_gnt_o,
  output logic                  lsu_rvalid_o,
  output logic [`CR_DATA_W-1:0] lsu_rdata_o,

  // local RAM side
  output logic                  core_req_o,
  output lsu_req_t              core_data_o,
  input  logic                  core_gnt_i,
  input  logic                  core_rvalid_i,
  input  logic [`CR_DATA_W-1:0] core_rdata_i,

  // external bus side
  output logic                  ext_req_o,
  output lsu_req_t              ext_data_o,
  input  logic                  ext_gnt_i,
  input  logic                  ext_rvalid_i,
  input  logic [`CR_DATA_W-1:0] ext_rdata_i
);

  logic      is_local;
  resp_src_e resp_src_d;
  resp_src_e resp_src_q;

  // region decode on the top address bits
  assign is_local = (lsu_data_i.addr[31:20] == `CR_REGION_TAG);

  assign core_req_o = lsu_req_i & is_local;
  assign ext_req_o  = lsu_req_i & ~is_local;

  // payload goes to both sides, only one of them sees a request
  assign core_data_o = lsu_data_i;
  assign ext_data_o  = lsu_data_i;

  // grant from whichever target was chosen
  always_comb begin
    lsu_gnt_o  = 1'b0;
    resp_src_d = resp_src_q;
    if (ext_req_o) begin
      lsu_gnt_o  = ext_gnt_i;
      resp_src_d = RESP_EXT;
    end else if (core_req_o) begin
      lsu_gnt_o  = core_gnt_i;
      resp_src_d = RESP_RAM;
    end
  end

  // remember who owes the next response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_src_q <= RESP_RAM;
    end else begin
      resp_src_q <= resp_src_d;
    end
  end

  // response merge
  assign lsu_rdata_o  = (resp_src_q == RESP_EXT) ? ext_rdata_i : core_rdata_i;
  assign lsu_rvalid_o = core_rvalid_i | ext_rvalid_i;

endmodule

//--- hw/core_region_top.sv
`timescale 1ns/1ps

`include "core_region_macros.svh"

module core_region_top
  import core_region_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,

  // core load/store port
  input  logic                    lsu_req_i,
  input  lsu_req_t                lsu_data_i,
  output logic                    lsu_gnt_o,
  output logic                    lsu_rvalid_o,
  output logic [`CR_DATA_W-1:0]   lsu_rdata_o,

  // external bus port
  output logic                    ext_req_o,
  output lsu_req_t                ext_data_o,
  input  logic                    ext_gnt_i,
  input  logic                    ext_rvalid_i,
  input  logic [`CR_DATA_W-1:0]   ext_rdata_i,

  // system port into the data RAM
  input  logic                    sys_req_i,
  input  ram_req_t                sys_data_i,
  output logic [`CR_DATA_W-1:0]   sys_rdata_o,

  input  logic [`CR_IRQ_N-1:0]    irq_i,
  output logic                    irq_o,
  output logic [`CR_IRQ_ID_W-1:0] irq_id_o
);

  // router to RAM arbiter
  logic                  core_req;
  lsu_req_t              core_data;
  logic                  core_gnt;
  logic                  core_rvalid;
  logic [`CR_DATA_W-1:0] core_rdata;

  // arbiter to RAM
  logic                  ram_en;
  ram_req_t              ram_data;
  logic [`CR_DATA_W-1:0] ram_rdata;

  lsu_router u_lsu_router (
    .clk           (clk),
    .rst_n         (rst_n),
    .lsu_req_i     (lsu_req_i),
    .lsu_data_i    (lsu_data_i),
    .lsu_gnt_o     (lsu_gnt_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_rdata_o   (lsu_rdata_o),
    .core_req_o    (core_req),
    .core_data_o   (core_data),
    .core_gnt_i    (core_gnt),
    .core_rvalid_i (core_rvalid),
    .core_rdata_i  (core_rdata),
    .ext_req_o     (ext_req_o),
    .ext_data_o    (ext_data_o),
    .ext_gnt_i     (ext_gnt_i),
    .ext_rvalid_i  (ext_rvalid_i),
    .ext_rdata_i   (ext_rdata_i)
  );

  data_ram_arbiter u_data_ram_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .sys_req_i     (sys_req_i),
    .sys_data_i    (sys_data_i),
    .sys_rdata_o   (sys_rdata_o),
    .core_req_i    (core_req),
    .core_data_i   (core_data),
    .core_gnt_o    (core_gnt),
    .core_rvalid_o (core_rvalid),
    .core_rdata_o  (core_rdata),
    .ram_en_o      (ram_en),
    .ram_data_o    (ram_data),
    .ram_rdata_i   (ram_rdata)
  );

  data_ram u_data_ram (
    .clk         (clk),
    .ram_en_i    (ram_en),
    .ram_data_i  (ram_data),
    .ram_rdata_o (ram_rdata)
  );

  irq_encoder u_irq_encoder (
    .irq_i    (irq_i),
    .irq_o    (irq_o),
    .irq_id_o (irq_id_o)
  );

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- test/core_region_assertions.sv
`timescale 1ns/1ps

module core_region_assertions (
  input logic clk,
  input logic rst_n,
  input logic gnt_i,
  input logic rvalid_i,
  input logic excl_a_i,
  input logic excl_b_i
);

  // grants still waiting for their response
  logic [3:0] outstanding;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= '0;
    end else if (gnt_i && !rvalid_i) begin
      outstanding <= outstanding + 4'd1;
    end else if (!gnt_i && rvalid_i && outstanding != 4'd0) begin
      outstanding <= outstanding - 4'd1;
    end
  end

  rvalid_after_gnt: assert property (
    @(posedge clk) disable iff (!rst_n) rvalid_i |-> (outstanding != 4'd0)
  ) else $error("rvalid seen without an earlier grant");

  // request pair in the router, grant against system port in the arbiter
  excl_pair: assert property (
    @(posedge clk) disable iff (!rst_n) !(excl_a_i && excl_b_i)
  ) else $error("two exclusive signals high in the same cycle");

endmodule

//--- test/tb_core_region.sv
`timescale 1ns/1ps

`include "core_region_macros.svh"

module tb_core_region
  import core_region_pkg::*;
();

  // operation counts per test group size the watchdog
  localparam int N_OPS       = 48 + 32 + 20 + 12 + 21;
  localparam int WATCHDOG_NS = N_OPS * 12 * 4 + 200;

  logic                    clk;
  logic                    rst_n;
  logic                    lsu_req_i;
  lsu_req_t                lsu_data_i;
  logic                    lsu_gnt_o;
  logic                    lsu_rvalid_o;
  logic [`CR_DATA_W-1:0]   lsu_rdata_o;
  logic                    ext_req_o;
  lsu_req_t                ext_data_o;
  logic                    ext_gnt_i;
  logic                    ext_rvalid_i;
  logic [`CR_DATA_W-1:0]   ext_rdata_i;
  logic                    sys_req_i;
  ram_req_t                sys_data_i;
  logic [`CR_DATA_W-1:0]   sys_rdata_o;
  logic [`CR_IRQ_N-1:0]    irq_i;
  logic                    irq_o;
  logic [`CR_IRQ_ID_W-1:0] irq_id_o;

  logic [`CR_DATA_W-1:0] model_mem [`CR_RAM_WORDS];
  lsu_req_t              pend_req_q [$];
  logic [31:0]           pend_exp_q [$];
  logic [31:0]           ext_data_q [$];
  logic                  sys_rd_pend = 1'b0;
  logic [31:0]           sys_rd_exp  = 32'h0;
  logic                  rvalid_due  = 1'b0;
  int                    n_checks    = 0;
  int                    n_errors    = 0;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  core_region_top dut (.*);

  bind lsu_router core_region_assertions u_router_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .gnt_i    (lsu_gnt_o),
    .rvalid_i (lsu_rvalid_o),
    .excl_a_i (core_req_o),
    .excl_b_i (ext_req_o)
  );

  bind data_ram_arbiter core_region_assertions u_arbiter_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .gnt_i    (core_gnt_o),
    .rvalid_i (core_rvalid_o),
    .excl_a_i (core_gnt_o),
    .excl_b_i (sys_req_i)
  );

  function automatic logic is_local(input logic [31:0] addr);
    return addr[31:20] == `CR_REGION_TAG;
  endfunction

  function automatic logic [31:0] local_addr(input int unsigned word);
    return {`CR_REGION_TAG, 8'h00, word[`CR_RAM_AW-1:0], 2'b00};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  be);
    logic [31:0] word;
    word = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        word[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return word;
  endfunction

  // local words come from the model and external words from the responder
  function automatic logic [31:0] expected_rdata(input lsu_req_t req, input logic [31:0] ext_word);
    if (is_local(req.addr)) begin
      return model_mem[req.addr[`CR_RAM_AW+1:2]];
    end
    return ext_word;
  endfunction

  function automatic logic [31:0] highest_irq(input logic [31:0] lines);
    for (int i = `CR_IRQ_N - 1; i >= 0; i--) begin
      if (lines[i]) begin
        return 32'(i);
      end
    end
    return 32'h0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // starts and ends on a falling edge
  task automatic lsu_access(input logic [31:0] addr, input logic we,
                            input logic [3:0] be, input logic [31:0] wdata);
    lsu_req_i        = 1'b1;
    lsu_data_i.addr  = addr;
    lsu_data_i.we    = we;
    lsu_data_i.be    = be;
    lsu_data_i.wdata = wdata;
    @(posedge clk);
    while (!lsu_gnt_o) begin
      @(posedge clk);
    end
    @(negedge clk);
    lsu_req_i = 1'b0;
    // external response has to return before the next request
    if (!is_local(addr)) begin
      @(posedge clk);
      while (!lsu_rvalid_o) begin
        @(posedge clk);
      end
      @(negedge clk);
    end
  endtask

  task automatic sys_access(input int unsigned word, input logic we,
                            input logic [31:0] wdata, input int unsigned cycles);
    sys_req_i        = 1'b1;
    sys_data_i.addr  = word[`CR_RAM_AW-1:0];
    sys_data_i.we    = we;
    sys_data_i.be    = 4'hf;
    sys_data_i.wdata = wdata;
    repeat (cycles) @(negedge clk);
    sys_req_i = 1'b0;
  endtask

  // external bus target with random grant and response delays
  initial begin : ext_responder
    int unsigned delay;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    forever begin
      @(posedge clk);
      if (ext_req_o) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge clk);
        @(negedge clk);
        ext_gnt_i = 1'b1;
        @(negedge clk);
        ext_gnt_i = 1'b0;
        delay = $urandom_range(2, 0);
        repeat (delay) @(negedge clk);
        ext_rdata_i = $urandom();
        ext_data_q.push_back(ext_rdata_i);
        ext_rvalid_i = 1'b1;
        @(negedge clk);
        ext_rvalid_i = 1'b0;
      end
    end
  end

  always @(posedge clk) begin : compare_proc
    lsu_req_t    req;
    logic [31:0] exp;
    if (rst_n) begin
      if (sys_rd_pend) begin
        check_value("sys_rdata_o", sys_rdata_o, sys_rd_exp);
        sys_rd_pend = 1'b0;
      end
      // local response is due one cycle after its grant
      if (rvalid_due) begin
        check_value("lsu_rvalid_o", {31'b0, lsu_rvalid_o}, 32'h1);
      end
      rvalid_due = lsu_req_i && lsu_gnt_o && is_local(lsu_data_i.addr);
      if (lsu_rvalid_o) begin
        if (pend_req_q.size() == 0) begin
          n_errors++;
          $display("error: lsu_rvalid_o high with no access outstanding at %0t", $time);
        end else begin
          req = pend_req_q.pop_front();
          exp = pend_exp_q.pop_front();
          if (!is_local(req.addr) && ext_data_q.size() != 0) begin
            exp = expected_rdata(req, ext_data_q.pop_front());
          end
          if (!req.we) begin
            check_value("lsu_rdata_o", lsu_rdata_o, exp);
          end
        end
      end
      if (sys_req_i) begin
        if (sys_data_i.we) begin
          model_mem[sys_data_i.addr] = merge_bytes(model_mem[sys_data_i.addr],
                                                   sys_data_i.wdata, sys_data_i.be);
        end else begin
          sys_rd_pend = 1'b1;
          sys_rd_exp  = model_mem[sys_data_i.addr];
        end
      end
      // system port holds the core off, otherwise the grant is immediate
      if (lsu_req_i && is_local(lsu_data_i.addr)) begin
        if (sys_req_i) begin
          check_value("lsu_gnt_o", {31'b0, lsu_gnt_o}, 32'h0);
        end else begin
          check_value("lsu_gnt_o", {31'b0, lsu_gnt_o}, 32'h1);
        end
      end
      if (ext_req_o) begin
        check_value("ext_data_o.addr", ext_data_o.addr, lsu_data_i.addr);
        check_value("ext_data_o.we", {31'b0, ext_data_o.we}, {31'b0, lsu_data_i.we});
        check_value("ext_data_o.be", {28'b0, ext_data_o.be}, {28'b0, lsu_data_i.be});
        check_value("ext_data_o.wdata", ext_data_o.wdata, lsu_data_i.wdata);
      end
      if (lsu_req_i && lsu_gnt_o) begin
        req = lsu_data_i;
        pend_req_q.push_back(req);
        pend_exp_q.push_back(expected_rdata(req, 32'h0));
        if (is_local(req.addr) && req.we) begin
          model_mem[req.addr[`CR_RAM_AW+1:2]] = merge_bytes(model_mem[req.addr[`CR_RAM_AW+1:2]],
                                                            req.wdata, req.be);
        end
      end
    end
  end

  initial begin : stimulus
    int unsigned words [16];
    logic [31:0] v;
    void'($urandom(32'h2abb));
    lsu_req_i  = 1'b0;
    lsu_data_i = '0;
    sys_req_i  = 1'b0;
    sys_data_i = '0;
    irq_i      = '0;
    @(posedge rst_n);
    @(negedge clk);
    check_value("lsu_rvalid_o", {31'b0, lsu_rvalid_o}, 32'h0);
    check_value("ext_req_o", {31'b0, ext_req_o}, 32'h0);

    // full word first, so every byte of the word is defined
    for (int i = 0; i < 16; i++) begin
      words[i] = i * 64 + $urandom_range(63, 0);
      lsu_access(local_addr(words[i]), 1'b1, 4'hf, $urandom());
      lsu_access(local_addr(words[i]), 1'b1, 4'($urandom_range(15, 0)), $urandom());
    end
    for (int i = 0; i < 16; i++) begin
      lsu_access(local_addr(words[i]), 1'b0, 4'hf, 32'h0);
    end

    // system port and core see each other's writes
    for (int i = 0; i < 8; i++) begin
      sys_access(900 + i, 1'b1, $urandom(), 1);
    end
    for (int i = 0; i < 8; i++) begin
      lsu_access(local_addr(900 + i), 1'b0, 4'hf, 32'h0);
    end
    for (int i = 0; i < 8; i++) begin
      lsu_access(local_addr(800 + i), 1'b1, 4'hf, $urandom());
    end
    for (int i = 0; i < 8; i++) begin
      sys_access(800 + i, 1'b0, 32'h0, 1);
    end

    // core read of the word the system port is busy writing
    for (int k = 0; k < 4; k++) begin
      fork
        sys_access(600 + k, 1'b1, $urandom(), $urandom_range(4, 1));
        lsu_access(local_addr(600 + k), 1'b0, 4'hf, 32'h0);
      join
    end

    // local and external accesses interleaved
    for (int i = 0; i < 12; i++) begin
      if (i % 2 == 0) begin
        lsu_access(local_addr(words[i]), 1'b0, 4'hf, 32'h0);
      end else begin
        lsu_access({4'h8, 28'($urandom())}, 1'($urandom_range(1, 0)), 4'hf, $urandom());
      end
    end

    // last vector is all zero
    for (int i = 0; i < 21; i++) begin
      v = (i == 20) ? 32'h0 : ($urandom() >> $urandom_range(31, 0));
      irq_i = v;
      @(posedge clk);
      check_value("irq_o", {31'b0, irq_o}, {31'b0, |v});
      check_value("irq_id_o", {27'b0, irq_id_o}, highest_irq(v));
      @(negedge clk);
    end

    while (pend_req_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    if (ext_data_q.size() != 0) begin
      n_errors++;
      $display("error: external responses left without a matching rvalid");
    end
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: run still busy after %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- build.f
+incdir+common
common/core_region_pkg.sv
data_mem/data_ram.sv
data_mem/data_ram_arbiter.sv
hw/irq_encoder.sv
hw/lsu_router.sv
hw/core_region_top.sv
test/tb_clk_gen.sv
test/core_region_assertions.sv
test/tb_core_region.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, then run and look for the pass line
verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_core_region -Mdir obj_dir -o sim_core_region \
  || { echo "build failed"; exit 1; }
./obj_dir/sim_core_region | tee /dev/stderr | grep "Simulation passed" > /dev/null \
  && echo "run ok" \
  || { echo "run failed"; exit 1; }
